/* rtl/ft2232_sim_top.sv */
/*
 * Chip-side model of the FT2232 synchronous FIFO, test mode only.
 * Connect the pins to the host-link design under test and feed a
 * reference clock; the model outputs it as the FIFO clock out of reset.
 * Status outputs report a failed check or a stopped-status message.
 */
`timescale 1ns/1ns

module ft2232_sim_top (
    input  logic       ref_clk_i,
    input  logic       ft2232_reset_n_i,
    output logic       fifo_clk_o,
    output logic       fifo_rxf_n_o,
    output logic       fifo_txe_n_o,
    input  logic       fifo_oe_n_i,
    input  logic       fifo_rd_n_i,
    input  logic       fifo_wr_n_i,
    inout  wire  [7:0] fifo_data_io,
    output logic       test_fail_o,
    output logic       test_stopped_o,
    output logic [7:0] stop_code_o
);

    ft_bus_if bus ();

    logic halt;

    // Clock stays low while the chip is held in reset
    assign fifo_clk_o = ft2232_reset_n_i ? ref_clk_i : 1'b0;

    // Chip drives the pads only while the host holds OE# low
    assign fifo_data_io = fifo_oe_n_i ? 8'bz : bus.tx_byte;

    assign bus.rx_byte = fifo_data_io;
    assign bus.oe_n = fifo_oe_n_i;
    assign bus.rd_n = fifo_rd_n_i;
    assign bus.wr_n = fifo_wr_n_i;

    ft_out_stream u_out_stream (
        .fifo_clk_i       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .halt_i           (halt),
        .bus              (bus.out_side),
        .rxf_n_o          (fifo_rxf_n_o)
    );

    ft_in_checker u_in_checker (
        .fifo_clk_i       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .bus              (bus.in_side),
        .txe_n_o          (fifo_txe_n_o),
        .halt_o           (halt),
        .fail_o           (test_fail_o),
        .stopped_o        (test_stopped_o),
        .stop_code_o      (stop_code_o)
    );

endmodule

/* rtl/ft_bus_if.sv */
/*
 * Byte bus and host strobes shared inside the FIFO model.
 * The top level fills rx_byte and the strobes from the pins; the
 * outbound machine supplies the byte that goes onto the pads.
 */
`timescale 1ns/1ns

interface ft_bus_if;

    // Byte seen on the pads while the host drives them
    logic [7:0] rx_byte;
    // Byte offered to the host while OE# is low
    logic [7:0] tx_byte;

    // Host strobes, all active low
    logic       oe_n;
    logic       rd_n;
    logic       wr_n;

    // Receive side of the chip, host reads
    modport out_side (
        input  oe_n,
        input  rd_n,
        output tx_byte
    );

    // Transmit side of the chip, host writes
    modport in_side (
        input rx_byte,
        input oe_n,
        input wr_n
    );

endinterface

/* rtl/ft_cfg.svh */
/*
 * Build-time settings of the FT2232 FIFO model.
 * Included by the outbound and inbound machines and by the testbench
 * model, so both sides agree on packet shape and gap lengths.
 */
`ifndef FT_CFG_SVH
`define FT_CFG_SVH

// ======================================================================
// Outbound stream shape
// ======================================================================

// Data packets sent between the start and the stop command
`define FT_DATA_PACKETS_COUNT 8'd2

// Payload bytes per outbound data packet
`define FT_DATA_PACKET_PAYLOAD 6'd16

// ======================================================================
// FIFO gap lengths in clock cycles
// ======================================================================

// RXF# high time, imitates an empty receive FIFO
`define FT_OUT_EMPTY_CYCLES 8'd3

// TXE# high time, imitates a full transmit FIFO
`define FT_IN_FULL_CYCLES 8'd2

// Test number sent after the start command, 3 is test_receive_send
`define FT_TEST_NUMBER 8'd3

`endif

/* rtl/ft_in_checker.sv */
/*
 * Inbound side of the FT2232 model.
 * Parses headers written by the host, checks data payload against a
 * running byte counter and keeps the error code of a stopped status.
 * TXE# drops for a short gap twice per data packet. A bad byte or an
 * unknown command raises fail_o and halt_o and closes both directions.
 */
`timescale 1ns/1ns

`include "ft_cfg.svh"

module ft_in_checker (
    input  logic        fifo_clk_i,
    input  logic        ft2232_reset_n_i,
    ft_bus_if.in_side   bus,
    output logic        txe_n_o,
    output logic        halt_o,
    output logic        fail_o,
    output logic        stopped_o,
    output logic [7:0]  stop_code_o
);

    ft_state_pkg::ft_in_state_e state;
    ft_proto_pkg::ft_cmd_e      last_cmd;
    ft_proto_pkg::ft_byte_u     rx;

    logic [5:0] total;
    logic [5:0] remaining;
    logic [7:0] exp_data;
    logic [7:0] gap_cnt;

    logic       xfer;
    logic [5:0] left_after;

    assign rx = bus.rx_byte;

    // Host writes while the pads are turned around towards the chip
    assign xfer = ~txe_n_o & bus.oe_n & ~bus.wr_n;

    assign left_after = remaining - 6'd1;

    // ==================================================================
    // Parser, data check and full-gap timer
    // ==================================================================
    always_ff @(posedge fifo_clk_i, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state <= ft_state_pkg::in_cmd;
            last_cmd <= ft_proto_pkg::cmd_test_data;
            total <= 6'd0;
            remaining <= 6'd0;
            exp_data <= 8'd0;
            gap_cnt <= 8'd0;
            txe_n_o <= 1'b0;
            halt_o <= 1'b0;
            fail_o <= 1'b0;
            stopped_o <= 1'b0;
            stop_code_o <= ft_proto_pkg::error_none;
        end else if (xfer) begin
            case (state)
                ft_state_pkg::in_cmd: begin
                    last_cmd <= rx.hdr.cmd;
                    total <= rx.hdr.count;
                    remaining <= rx.hdr.count;
                    case (rx.hdr.cmd)
                        ft_proto_pkg::cmd_test_data: begin
                            if (rx.hdr.count != 6'd0) begin
                                state <= ft_state_pkg::in_payload;
                            end
                        end

                        ft_proto_pkg::cmd_test_stopped: begin
                            // Host is done, stop the outbound stream
                            halt_o <= 1'b1;
                            if (rx.hdr.count != 6'd0) begin
                                state <= ft_state_pkg::in_payload;
                            end
                        end

                        default: begin
                            fail_o <= 1'b1;
                            halt_o <= 1'b1;
                            txe_n_o <= 1'b1;
                            state <= ft_state_pkg::in_idle;
                        end
                    endcase
                end

                ft_state_pkg::in_payload: begin
                    if (last_cmd == ft_proto_pkg::cmd_test_stopped) begin
                        // First byte is the error code, the rest is dropped
                        if (remaining == total) begin
                            stop_code_o <= rx.data;
                            stopped_o <= 1'b1;
                        end
                        remaining <= left_after;
                        if (remaining == 6'd1) begin
                            state <= ft_state_pkg::in_cmd;
                        end
                    end else if (rx.data == exp_data) begin
                        exp_data <= exp_data + 8'd1;
                        remaining <= left_after;
                        if (remaining == 6'd1) begin
                            state <= ft_state_pkg::in_cmd;
                        end else if (`FT_IN_FULL_CYCLES != 8'd0 &&
                                (left_after == total / 2 || left_after == total / 4)) begin
                            // Full FIFO for a few cycles
                            txe_n_o <= 1'b1;
                            gap_cnt <= `FT_IN_FULL_CYCLES;
                        end
                    end else begin
                        // Data mismatch
                        fail_o <= 1'b1;
                        halt_o <= 1'b1;
                        txe_n_o <= 1'b1;
                        state <= ft_state_pkg::in_idle;
                    end
                end

                default: begin
                    txe_n_o <= 1'b1;
                end
            endcase
        end else if (txe_n_o && state != ft_state_pkg::in_idle) begin
            gap_cnt <= gap_cnt - 8'd1;
            if (gap_cnt == 8'd1) begin
                txe_n_o <= 1'b0;
            end
        end
    end

endmodule

/* rtl/ft_out_stream.sv */
/*
 * Outbound byte sequencer of the FT2232 model.
 * Sends the start command and test number, then the configured data
 * packets and a stop command. RXF# is dropped for a short gap twice per
 * packet; halt from the inbound side closes the stream for good.
 */
`timescale 1ns/1ns

`include "ft_cfg.svh"

module ft_out_stream (
    input  logic               fifo_clk_i,
    input  logic               ft2232_reset_n_i,
    input  logic               halt_i,
    ft_bus_if.out_side         bus,
    output logic               rxf_n_o
);

    ft_state_pkg::ft_out_state_e state;

    logic [7:0] packets_left;
    logic [5:0] payload_left;
    logic [7:0] data_cnt;
    logic [7:0] gap_cnt;
    logic       rxf_q;

    logic       xfer;
    logic [7:0] next_byte;
    logic [5:0] remaining;

    // Packs a command header into one bus byte
    function automatic logic [7:0] mk_header(input ft_proto_pkg::ft_cmd_e cmd,
                                             input logic [5:0] count);
        ft_proto_pkg::ft_byte_u b;
        b.hdr.cmd = cmd;
        b.hdr.count = count;
        return b.data;
    endfunction

    // Halt closes the FIFO in the same cycle it shows up
    assign rxf_n_o = rxf_q | halt_i;

    assign xfer = ~rxf_n_o & ~bus.oe_n & ~bus.rd_n;

    // Payload bytes left once the current transfer is done
    assign remaining = payload_left - 6'd1;

    // ==================================================================
    // Byte offered at the next transfer
    // ==================================================================
    always_comb begin
        case (state)
            ft_state_pkg::out_start_cmd:
                next_byte = mk_header(ft_proto_pkg::cmd_test_start, 6'd1);
            ft_state_pkg::out_start_payload:
                next_byte = `FT_TEST_NUMBER;
            ft_state_pkg::out_data_cmd:
                next_byte = mk_header(ft_proto_pkg::cmd_test_data, `FT_DATA_PACKET_PAYLOAD);
            ft_state_pkg::out_data_payload:
                next_byte = data_cnt;
            ft_state_pkg::out_stop_cmd:
                next_byte = mk_header(ft_proto_pkg::cmd_test_stop, 6'd0);
            default:
                next_byte = 8'h00;
        endcase
    end

    always_ff @(posedge fifo_clk_i, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            bus.tx_byte <= 8'h00;
        end else if (xfer) begin
            bus.tx_byte <= next_byte;
        end
    end

    // ==================================================================
    // Sequencer and empty-gap timer
    // ==================================================================
    always_ff @(posedge fifo_clk_i, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state <= ft_state_pkg::out_start_cmd;
            packets_left <= 8'd0;
            payload_left <= 6'd0;
            data_cnt <= 8'd0;
            gap_cnt <= 8'd0;
            rxf_q <= 1'b0;
        end else if (halt_i) begin
            state <= ft_state_pkg::out_idle;
            rxf_q <= 1'b1;
        end else if (xfer) begin
            case (state)
                ft_state_pkg::out_start_cmd: begin
                    packets_left <= `FT_DATA_PACKETS_COUNT;
                    data_cnt <= 8'd0;
                    state <= ft_state_pkg::out_start_payload;
                end

                ft_state_pkg::out_start_payload: begin
                    if (`FT_TEST_NUMBER == ft_proto_pkg::test_receive ||
                            `FT_TEST_NUMBER == ft_proto_pkg::test_receive_send) begin
                        state <= ft_state_pkg::out_data_cmd;
                    end else begin
                        // test_send ends the stream here
                        state <= ft_state_pkg::out_idle;
                        rxf_q <= 1'b1;
                    end
                end

                ft_state_pkg::out_data_cmd: begin
                    payload_left <= `FT_DATA_PACKET_PAYLOAD;
                    state <= ft_state_pkg::out_data_payload;
                end

                ft_state_pkg::out_data_payload: begin
                    data_cnt <= data_cnt + 8'd1;
                    payload_left <= remaining;
                    if (payload_left == 6'd1) begin
                        packets_left <= packets_left - 8'd1;
                        if (packets_left == 8'd1) begin
                            state <= ft_state_pkg::out_stop_cmd;
                        end else begin
                            state <= ft_state_pkg::out_data_cmd;
                        end
                    end
                    // Empty FIFO at the half and quarter marks
                    if (`FT_OUT_EMPTY_CYCLES != 8'd0 &&
                            (remaining == `FT_DATA_PACKET_PAYLOAD / 2 ||
                             remaining == `FT_DATA_PACKET_PAYLOAD / 4)) begin
                        rxf_q <= 1'b1;
                        gap_cnt <= `FT_OUT_EMPTY_CYCLES;
                    end
                end

                ft_state_pkg::out_stop_cmd: begin
                    state <= ft_state_pkg::out_idle;
                    rxf_q <= 1'b1;
                end

                default: begin
                    rxf_q <= 1'b1;
                end
            endcase
        end else if (rxf_q && state != ft_state_pkg::out_idle) begin
            gap_cnt <= gap_cnt - 8'd1;
            if (gap_cnt == 8'd1) begin
                rxf_q <= 1'b0;
            end
        end
    end

endmodule

/* rtl/ft_proto_pkg.sv */
/*
 * Host-link protocol types shared by the FIFO model machines.
 * A bus byte is either a command header or a raw payload byte, and the
 * union below lets the same byte be read either way.
 */
package ft_proto_pkg;

    // Command codes in the two top bits of a header byte
    // Inbound 00 and 10 are not valid and end the test
    typedef enum logic [1:0] {
        cmd_test_start   = 2'b00,
        cmd_test_data    = 2'b01,
        cmd_test_stop    = 2'b10,
        cmd_test_stopped = 2'b11
    } ft_cmd_e;

    // Header layout
    typedef struct packed {
        ft_cmd_e    cmd;
        logic [5:0] count;
    } ft_cmd_s;

    // One bus byte, decoded as header or payload
    typedef union packed {
        ft_cmd_s    hdr;
        logic [7:0] data;
    } ft_byte_u;

    // Test numbers carried as the start command payload
    typedef enum logic [7:0] {
        test_send         = 8'd1,
        test_receive      = 8'd2,
        test_receive_send = 8'd3
    } ft_test_e;

    // Error code of a clean stop
    localparam logic [7:0] error_none = 8'd0;

endpackage

/* rtl/ft_state_pkg.sv */
/*
 * State encodings of the outbound sequencer and the inbound checker.
 */
package ft_state_pkg;

    // Outbound byte sequencer
    typedef enum logic [2:0] {
        out_start_cmd     = 3'd0,
        out_start_payload = 3'd1,
        out_data_cmd      = 3'd2,
        out_data_payload  = 3'd3,
        out_stop_cmd      = 3'd4,
        out_idle          = 3'd5
    } ft_out_state_e;

    // Inbound command parser
    typedef enum logic [1:0] {
        in_cmd     = 2'd0,
        in_payload = 2'd1,
        in_idle    = 2'd3
    } ft_in_state_e;

endpackage

/* tb/ft2232_checker.sv */
/*
 * Bus monitor for the FT2232 model testbench.
 * Samples read and write transfers on the FIFO clock. It keeps its own
 * model of the outbound byte sequence, the inbound parser and both gap
 * rules, and compares every DUT output with that model each cycle.
 */
`timescale 1ns/1ns

`include "ft_cfg.svh"

module ft2232_checker (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       oe_n_i,
    input  logic       rd_n_i,
    input  logic       wr_n_i,
    input  logic [7:0] data_i,
    input  logic       rxf_n_i,
    input  logic       txe_n_i,
    input  logic       fail_i,
    input  logic       stopped_i,
    input  logic [7:0] stop_code_i,
    output int         error_count_o
);

    logic [7:0] out_q[$];
    bit         gap_q[$];
    int         out_idx;
    int         out_gap;
    bit         rd_pending;
    logic [7:0] rd_exp;

    int         in_state;
    logic [1:0] last_cmd;
    int         total;
    int         left;
    logic [7:0] exp_data;
    int         in_gap;
    bit         halted;
    bit         failed;
    bit         stopped;
    logic [7:0] code;

    initial error_count_o = 0;

    task automatic compare(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
            error_count_o++;
        end
    endtask

    // Expected outbound bytes with a flag for the empty gap after each
    task automatic build_out_seq();
        logic [7:0] val;
        int         rem;
        out_q.delete();
        gap_q.delete();
        val = 8'd0;
        out_q.push_back({2'b00, 6'd1});
        gap_q.push_back(1'b0);
        out_q.push_back(`FT_TEST_NUMBER);
        gap_q.push_back(1'b0);
        if (`FT_TEST_NUMBER == 8'd2 || `FT_TEST_NUMBER == 8'd3) begin
            for (int p = 0; p < `FT_DATA_PACKETS_COUNT; p++) begin
                out_q.push_back({2'b01, `FT_DATA_PACKET_PAYLOAD});
                gap_q.push_back(1'b0);
                for (int b = 0; b < `FT_DATA_PACKET_PAYLOAD; b++) begin
                    rem = `FT_DATA_PACKET_PAYLOAD - 1 - b;
                    out_q.push_back(val);
                    gap_q.push_back(`FT_OUT_EMPTY_CYCLES != 0 &&
                        (rem == `FT_DATA_PACKET_PAYLOAD / 2 ||
                         rem == `FT_DATA_PACKET_PAYLOAD / 4));
                    val = val + 8'd1;
                end
            end
            out_q.push_back({2'b10, 6'd0});
            gap_q.push_back(1'b0);
        end
    endtask

    task automatic reset_model();
        build_out_seq();
        out_idx = 0;
        out_gap = 0;
        rd_pending = 0;
        in_state = 0;
        last_cmd = 2'b01;
        total = 0;
        left = 0;
        exp_data = 8'd0;
        in_gap = 0;
        halted = 0;
        failed = 0;
        stopped = 0;
        code = 8'd0;
    endtask

    task automatic fail_inbound();
        failed = 1;
        halted = 1;
        in_state = 2;
    endtask

    // One written byte through the inbound parser rules
    task automatic take_in_byte(input logic [7:0] b);
        if (in_state == 0) begin
            last_cmd = b[7:6];
            total = b[5:0];
            left = b[5:0];
            if (b[7:6] == ft_proto_pkg::cmd_test_data || b[7:6] == ft_proto_pkg::cmd_test_stopped) begin
                if (b[7:6] == ft_proto_pkg::cmd_test_stopped)
                    halted = 1;
                if (left != 0)
                    in_state = 1;
            end else begin
                fail_inbound();
            end
        end else if (in_state == 1) begin
            if (last_cmd == ft_proto_pkg::cmd_test_stopped) begin
                if (left == total) begin
                    code = b;
                    stopped = 1;
                end
                left--;
                if (left == 0)
                    in_state = 0;
            end else if (b == exp_data) begin
                exp_data = exp_data + 8'd1;
                left--;
                if (left == 0)
                    in_state = 0;
                else if (left == total / 2 || left == total / 4)
                    in_gap = `FT_IN_FULL_CYCLES;
            end else begin
                fail_inbound();
            end
        end
    endtask

    // ==================================================================
    // Per-cycle comparison, then model update
    // ==================================================================
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reset_model();
        end else begin
            compare("rxf_n", rxf_n_i, out_gap > 0 || out_idx >= out_q.size() || halted);
            compare("txe_n", txe_n_i, in_gap > 0 || failed);
            compare("test_fail", fail_i, failed);
            compare("test_stopped", stopped_i, stopped);
            compare("stop_code", stop_code_i, code);
            if (rd_pending) begin
                compare("read byte", data_i, rd_exp);
                rd_pending = 0;
            end
            if (out_gap > 0)
                out_gap--;
            if (in_gap > 0)
                in_gap--;
            if (!rxf_n_i && !oe_n_i && !rd_n_i) begin
                if (out_idx >= out_q.size()) begin
                    $display("read transfer at %0t after the outbound stream ended", $time);
                    error_count_o++;
                end else begin
                    rd_exp = out_q[out_idx];
                    rd_pending = 1;
                    if (gap_q[out_idx])
                        out_gap = `FT_OUT_EMPTY_CYCLES;
                    out_idx++;
                end
            end
            if (!txe_n_i && oe_n_i && !wr_n_i)
                take_in_byte(data_i);
        end
    end

endmodule

/* tb/tb_ft2232.sv */
/*
 * Testbench of the FT2232 FIFO model.
 * Runs one clean session with random read and write bursts and a
 * stopped status, then a second session after reset that sends a bad
 * data byte or an unknown command. ft2232_checker does the comparing.
 */
`timescale 1ns/1ns

`include "ft_cfg.svh"

module tb_ft2232;

    localparam int N_IN_PKTS = 4;
    localparam int OUT_BYTES = (`FT_TEST_NUMBER == 8'd1) ? 2 :
        3 + `FT_DATA_PACKETS_COUNT * (1 + `FT_DATA_PACKET_PAYLOAD);
    localparam int GAP_CYCLES = 4 * `FT_DATA_PACKETS_COUNT * `FT_OUT_EMPTY_CYCLES +
        2 * N_IN_PKTS * `FT_IN_FULL_CYCLES;
    localparam int WATCH_CYCLES = 40 * (2 * OUT_BYTES + N_IN_PKTS * 64 + 70 + GAP_CYCLES + 16);

    logic       ref_clk;
    logic       rst_n;
    logic       oe_n;
    logic       rd_n;
    logic       wr_n;
    logic [7:0] host_data;
    wire  [7:0] fifo_data;
    logic       fifo_clk;
    logic       rxf_n;
    logic       txe_n;
    logic       test_fail;
    logic       test_stopped;
    logic [7:0] stop_code;
    int         checker_errors;

    int         seed = 32'h04d9_ff2c;
    int         tb_errors = 0;
    int         reads_done;
    logic [7:0] wq[$];
    logic [7:0] sent_code;

    // Host drives the pads only while OE# is high
    assign fifo_data = oe_n ? host_data : 8'bz;

    ft2232_sim_top dut (
        .ref_clk_i(ref_clk), .ft2232_reset_n_i(rst_n), .fifo_clk_o(fifo_clk),
        .fifo_rxf_n_o(rxf_n), .fifo_txe_n_o(txe_n), .fifo_oe_n_i(oe_n),
        .fifo_rd_n_i(rd_n), .fifo_wr_n_i(wr_n), .fifo_data_io(fifo_data),
        .test_fail_o(test_fail), .test_stopped_o(test_stopped), .stop_code_o(stop_code)
    );

    ft2232_checker u_checker (
        .clk_i(fifo_clk), .rst_n_i(rst_n), .oe_n_i(oe_n), .rd_n_i(rd_n), .wr_n_i(wr_n),
        .data_i(fifo_data), .rxf_n_i(rxf_n), .txe_n_i(txe_n), .fail_i(test_fail),
        .stopped_i(test_stopped), .stop_code_i(stop_code), .error_count_o(checker_errors)
    );

    initial begin
        ref_clk = 1'b0;
        forever #10 ref_clk = ~ref_clk;
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge ref_clk);
        $display("timeout, the host driver did not finish within %0d cycles", WATCH_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic int rand_between(input int lo, input int hi);
        return lo + (($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    // Waits one clock and counts the transfers the DUT accepted
    task automatic step();
        @(posedge ref_clk);
        if (!rxf_n && !oe_n && !rd_n)
            reads_done++;
        if (!txe_n && oe_n && !wr_n && wq.size() > 0)
            void'(wq.pop_front());
    endtask

    task automatic read_burst(input int n);
        for (int i = 0; i < n; i++) begin
            step();
            oe_n <= 1'b0;
            wr_n <= 1'b1;
            rd_n <= $random(seed) & 1;
        end
        // OE# stays low one more cycle so the last byte can be sampled
        step();
        rd_n <= 1'b1;
    endtask

    task automatic write_burst(input int n);
        for (int i = 0; i < n; i++) begin
            step();
            oe_n <= 1'b1;
            rd_n <= 1'b1;
            if (wq.size() > 0) begin
                host_data <= wq[0];
                wr_n <= $random(seed) & 1;
            end else begin
                wr_n <= 1'b1;
            end
        end
        step();
        wr_n <= 1'b1;
    endtask

    task automatic apply_reset();
        step();
        rst_n <= 1'b0;
        oe_n <= 1'b1;
        rd_n <= 1'b1;
        wr_n <= 1'b1;
        repeat (8) begin
            step();
            #1;
            if (fifo_clk !== 1'b0) begin
                $display("FIFO clock toggles during reset at %0t", $time);
                tb_errors++;
            end
        end
        rst_n <= 1'b1;
        reads_done = 0;
    endtask

    // ==================================================================
    // Stimulus
    // ==================================================================
    initial begin
        logic [7:0] val;
        int         len;
        int         bad;
        rst_n = 1'b1;
        oe_n = 1'b1;
        rd_n = 1'b1;
        wr_n = 1'b1;
        host_data = 8'h00;
        val = 8'd0;

        // Reset edge ahead of the first clock edge
        #1;
        rst_n <= 1'b0;

        // Clean session
        apply_reset();
        for (int p = 0; p < N_IN_PKTS; p++) begin
            len = rand_between(1, 63);
            wq.push_back({2'b01, len[5:0]});
            for (int b = 0; b < len; b++) begin
                wq.push_back(val);
                val = val + 8'd1;
            end
        end
        while (reads_done < OUT_BYTES || wq.size() > 0) begin
            if (reads_done < OUT_BYTES)
                read_burst(rand_between(1, 8));
            if (wq.size() > 0)
                write_burst(rand_between(1, 8));
        end
        sent_code = $random(seed);
        len = rand_between(1, 3);
        wq.push_back({2'b11, len[5:0]});
        wq.push_back(sent_code);
        for (int b = 1; b < len; b++)
            wq.push_back($random(seed));
        while (wq.size() > 0)
            write_burst(rand_between(1, 8));
        repeat (20) step();
        if (test_stopped !== 1'b1 || stop_code !== sent_code) begin
            $display("mismatch at %0t: stopped %b code %h, expected 1 %h",
                     $time, test_stopped, stop_code, sent_code);
            tb_errors++;
        end

        // Faulty session
        apply_reset();
        len = rand_between(1, 63);
        if ($random(seed) & 1) begin
            wq.push_back({(($random(seed) & 1) ? 2'b10 : 2'b00), len[5:0]});
        end else begin
            bad = rand_between(0, len - 1);
            wq.push_back({2'b01, len[5:0]});
            for (int b = 0; b < len; b++)
                wq.push_back((b == bad) ? (b[7:0] ^ rand_between(1, 255)) : b[7:0]);
        end
        while (!test_fail && wq.size() > 0) begin
            read_burst(rand_between(1, 8));
            write_burst(rand_between(1, 8));
        end
        wq.delete();
        read_burst(20);
        write_burst(20);
        if (test_fail !== 1'b1) begin
            $display("the bad byte or unknown command was not flagged as a failure");
            tb_errors++;
        end

        $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/ft_proto_pkg.sv
rtl/ft_state_pkg.sv
rtl/ft_bus_if.sv
rtl/ft_out_stream.sv
rtl/ft_in_checker.sv
rtl/ft2232_sim_top.sv
tb/ft2232_checker.sv
tb/tb_ft2232.sv
